/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module prefetcher_tb -f tb.f -o prefetcher_sim
output=$(./obj_dir/prefetcher_sim)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "sim passed"; then
	exit 0
else
	exit 1
fi

/* source/prefetch_buffer.sv */
module prefetch_buffer #(
	parameter int entries = 4
) (
	input logic clk,
	input logic prefetch_counter_reset,
	input logic fill,
	input logic arm,
	input logic invalidate,
	input logic serve_hit,
	input logic [$clog2(entries)-1:0] fill_index,
	input logic [$clog2(entries)-1:0] hit_index,
	input prefetch_pkg::line_t pmem_rdata,
	output logic [entries-1:0] ready_bits,
	output prefetch_pkg::line_t l2_rdata
);

	import prefetch_pkg::*;

	// prefetched line storage
	line_t lines [entries];

	always_ff @(posedge clk)
	begin
		if (fill)
			lines[fill_index] <= pmem_rdata;
	end

	// ready means the stored line matches pmem for that tag
	always_ff @(posedge clk)
	begin
		if (prefetch_counter_reset)
			ready_bits <= '0;
		else
		begin
			if (arm)
				ready_bits[fill_index] <= 1'b0;
			if (fill)
				ready_bits[fill_index] <= 1'b1;
			// write through makes the buffered copy stale
			if (invalidate)
				ready_bits[hit_index] <= 1'b0;
		end
	end

	// buffered line on a hit, pass-through from pmem on a miss
	assign l2_rdata = serve_hit ? lines[hit_index] : pmem_rdata;

	a_no_fill_invalidate_clash: assert property (
		@(posedge clk) disable iff (prefetch_counter_reset)
		!(fill && invalidate && (fill_index == hit_index))
	);

	// control only answers from the buffer when the entry was ready at check time
	a_hit_is_ready: assert property (
		@(posedge clk) disable iff (prefetch_counter_reset)
		serve_hit |-> ready_bits[hit_index]
	);

endmodule

/* source/prefetch_control.sv */
module prefetch_control #(
	parameter int entries = 4,
	parameter int grace_time = 20
) (
	input logic clk,
	input logic prefetch_counter_reset,
	input prefetch_pkg::addr_t orb,
	input logic prefetch_en,
	input prefetch_pkg::addr_t l2_address,
	input logic l2_read,
	input logic l2_write,
	input prefetch_pkg::line_t l2_wdata,
	output logic l2_resp,
	output prefetch_pkg::addr_t pmem_address,
	output logic pmem_read,
	output logic pmem_write,
	output prefetch_pkg::line_t pmem_wdata,
	input logic pmem_resp,
	input logic hit,
	input logic [$clog2(entries)-1:0] hit_index,
	input logic already_held,
	input logic [entries-1:0] ready_bits,
	output prefetch_pkg::addr_t tags [entries],
	output logic [entries-1:0] valid,
	output logic fill,
	output logic arm,
	output logic invalidate,
	output logic serve_hit,
	output logic [$clog2(entries)-1:0] fill_index
);

	import prefetch_pkg::*;

	localparam int index_width = $clog2(entries);
	// room for grace_time + 1 so the age saturates past the limit
	localparam int age_width = $clog2(grace_time + 2);

	ctrl_state_t state;
	ctrl_state_t next_state;
	logic [age_width-1:0] age;
	logic [index_width-1:0] next_index;
	logic l2_request;
	logic load_orb;
	logic young;
	logic refetch;

	assign l2_request = l2_read | l2_write;
	assign next_index = fill_index + index_width'(1);
	assign young = (age <= age_width'(grace_time));

	// new orb is taken only while the L2 side is quiet
	assign load_orb = (state == st_idle) && !l2_request && prefetch_en && !already_held;

	// entry at the pointer lost its data, either pre-empted or written
	assign refetch = valid[fill_index] && !ready_bits[fill_index];

	always_comb
	begin
		next_state = state;
		case (state)
			st_idle:
			begin
				if (l2_request)
					next_state = st_check;
				else if (load_orb || refetch)
					next_state = st_prefetch;
			end
			st_prefetch:
			begin
				// a finished read is kept even if a request just arrived
				if (pmem_resp)
					next_state = st_idle;
				else if (l2_request && young)
					next_state = st_check;
			end
			st_check:
			begin
				if (!l2_request)
					next_state = st_idle;
				else if (l2_read && hit && ready_bits[hit_index])
					next_state = st_hit_resp;
				else
					next_state = st_miss;
			end
			st_miss:
			begin
				if (pmem_resp)
					next_state = st_idle;
			end
			st_hit_resp:
			begin
				next_state = st_idle;
			end
			default:
			begin
				next_state = st_idle;
			end
		endcase
	end

	always_comb
	begin
		pmem_address = l2_address;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		l2_resp = 1'b0;
		fill = 1'b0;
		arm = 1'b0;
		invalidate = 1'b0;
		serve_hit = 1'b0;
		case (state)
			st_prefetch:
			begin
				pmem_address = tags[fill_index];
				pmem_read = 1'b1;
				fill = pmem_resp;
				// keep the stale line of a reused slot from hitting
				arm = !pmem_resp;
			end
			st_check:
			begin
				invalidate = l2_write && hit;
			end
			st_miss:
			begin
				pmem_read = l2_read;
				pmem_write = l2_write;
				l2_resp = pmem_resp;
			end
			st_hit_resp:
			begin
				l2_resp = 1'b1;
				serve_hit = 1'b1;
			end
			default:
			begin
			end
		endcase
	end

	// write data is only ever the L2 write line
	assign pmem_wdata = l2_wdata;

	always_ff @(posedge clk)
	begin
		if (prefetch_counter_reset)
		begin
			state <= st_idle;
			fill_index <= '0;
			valid <= '0;
			age <= '0;
		end
		else
		begin
			state <= next_state;
			if (load_orb)
			begin
				fill_index <= next_index;
				valid[next_index] <= 1'b1;
			end
			// age of the prefetch in flight
			if (state == st_prefetch)
			begin
				if (young)
					age <= age + age_width'(1);
			end
			else
				age <= '0;
		end
	end

	// tag of the slot just claimed by the pointer
	always_ff @(posedge clk)
	begin
		if (load_orb)
			tags[next_index] <= orb;
	end

	a_pmem_one_op: assert property (
		@(posedge clk) disable iff (prefetch_counter_reset)
		!(pmem_read && pmem_write)
	);

endmodule

/* source/prefetch_lookup.sv */
module prefetch_lookup #(
	parameter int entries = 4
) (
	input prefetch_pkg::addr_t tags [entries],
	input logic [entries-1:0] valid,
	input prefetch_pkg::addr_t l2_address,
	input prefetch_pkg::addr_t orb,
	output logic hit,
	output logic [$clog2(entries)-1:0] hit_index,
	output logic already_held
);

	localparam int index_width = $clog2(entries);

	logic [entries-1:0] l2_match;
	logic [entries-1:0] orb_match;

	// per-entry compares, only valid entries count
	always_comb
	begin
		for (int i = 0; i < entries; i++)
		begin
			l2_match[i] = valid[i] && (tags[i] == l2_address);
			orb_match[i] = valid[i] && (tags[i] == orb);
		end
	end

	// an orb that is already a tag must not be loaded a second time
	assign already_held = |orb_match;

	// lowest matching index wins
	always_comb
	begin
		hit = 1'b0;
		hit_index = '0;
		for (int i = entries - 1; i >= 0; i--)
		begin
			if (l2_match[i])
			begin
				hit = 1'b1;
				hit_index = index_width'(i);
			end
		end
	end

	// control never loads a duplicate tag, so two matches mean the
	// already_held path was bypassed
	always_comb
	begin
		assert ($onehot0(l2_match))
		else
			$error("lookup: more than one valid entry matches the L2 address");
	end

endmodule

/* source/prefetch_pkg.sv */
package prefetch_pkg;

	// line geometry shared by the L2 and pmem sides
	localparam int addr_width = 32;
	localparam int line_width = 256;

	// byte address of a line
	typedef logic [addr_width-1:0] addr_t;

	// one full cache line
	typedef logic [line_width-1:0] line_t;

	// control machine states
	//   st_idle      waiting for an L2 request or an orb
	//   st_prefetch  pmem read for the entry at fill_index
	//   st_miss      L2 request forwarded to pmem
	//   st_check     tag compare result is looked at
	//   st_hit_resp  line returned from the buffer
	typedef enum logic [2:0] {
		st_idle     = 3'd0,
		st_prefetch = 3'd1,
		st_miss     = 3'd2,
		st_check    = 3'd3,
		st_hit_resp = 3'd4
	} ctrl_state_t;

endpackage

/* source/prefetcher.sv */
module prefetcher #(
	parameter int entries = 4,
	parameter int grace_time = 20
) (
	input logic clk,
	input logic prefetch_counter_reset,
	// prefetch request
	input prefetch_pkg::addr_t orb,
	input logic prefetch_en,
	// L2 side
	input prefetch_pkg::addr_t l2_address,
	input logic l2_read,
	input logic l2_write,
	input prefetch_pkg::line_t l2_wdata,
	output prefetch_pkg::line_t l2_rdata,
	output logic l2_resp,
	// pmem side
	output prefetch_pkg::addr_t pmem_address,
	output logic pmem_read,
	output logic pmem_write,
	output prefetch_pkg::line_t pmem_wdata,
	input prefetch_pkg::line_t pmem_rdata,
	input logic pmem_resp
);

	import prefetch_pkg::*;

	localparam int index_width = $clog2(entries);

	addr_t tags [entries];
	logic [entries-1:0] valid;
	logic [entries-1:0] ready_bits;
	logic hit;
	logic [index_width-1:0] hit_index;
	logic already_held;
	logic [index_width-1:0] fill_index;
	logic fill;
	logic arm;
	logic invalidate;
	logic serve_hit;

	prefetch_lookup #(
		.entries(entries)
	) u_lookup (
		.tags(tags),
		.valid(valid),
		.l2_address(l2_address),
		.orb(orb),
		.hit(hit),
		.hit_index(hit_index),
		.already_held(already_held)
	);

	prefetch_control #(
		.entries(entries),
		.grace_time(grace_time)
	) u_control (
		.clk(clk),
		.prefetch_counter_reset(prefetch_counter_reset),
		.orb(orb),
		.prefetch_en(prefetch_en),
		.l2_address(l2_address),
		.l2_read(l2_read),
		.l2_write(l2_write),
		.l2_wdata(l2_wdata),
		.l2_resp(l2_resp),
		.pmem_address(pmem_address),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_wdata(pmem_wdata),
		.pmem_resp(pmem_resp),
		.hit(hit),
		.hit_index(hit_index),
		.already_held(already_held),
		.ready_bits(ready_bits),
		.tags(tags),
		.valid(valid),
		.fill(fill),
		.arm(arm),
		.invalidate(invalidate),
		.serve_hit(serve_hit),
		.fill_index(fill_index)
	);

	prefetch_buffer #(
		.entries(entries)
	) u_buffer (
		.clk(clk),
		.prefetch_counter_reset(prefetch_counter_reset),
		.fill(fill),
		.arm(arm),
		.invalidate(invalidate),
		.serve_hit(serve_hit),
		.fill_index(fill_index),
		.hit_index(hit_index),
		.pmem_rdata(pmem_rdata),
		.ready_bits(ready_bits),
		.l2_rdata(l2_rdata)
	);

endmodule

/* tb.f */
source/prefetch_pkg.sv
source/prefetch_lookup.sv
source/prefetch_control.sv
source/prefetch_buffer.sv
source/prefetcher.sv
testbench/pmem_model.sv
testbench/prefetcher_tb.sv

/* testbench/pmem_model.sv */
module pmem_model #(
	parameter int latency = 4
) (
	input logic clk,
	input logic prefetch_counter_reset,
	input prefetch_pkg::addr_t pmem_address,
	input logic pmem_read,
	input logic pmem_write,
	input prefetch_pkg::line_t pmem_wdata,
	output prefetch_pkg::line_t pmem_rdata,
	output logic pmem_resp
);

	import prefetch_pkg::*;

	// 32 KB window of writable lines
	localparam int lines = 1024;

	line_t mem [lines];
	logic [lines-1:0] written;
	logic [$clog2(lines)-1:0] index;
	int wait_count;

	assign index = pmem_address[5 +: $clog2(lines)];

	// every word mixes in the full address
	function automatic line_t fill_pattern(input addr_t a);
		line_t l;
		for (int i = 0; i < 8; i++)
			l[i*32 +: 32] = a ^ (32'(i) * 32'h1111_1111);
		return l;
	endfunction

	always_ff @(posedge clk)
	begin
		if (prefetch_counter_reset)
		begin
			pmem_resp <= 1'b0;
			wait_count <= 0;
			written <= '0;
		end
		else if (pmem_resp)
		begin
			pmem_resp <= 1'b0;
			wait_count <= 0;
		end
		else if (pmem_read || pmem_write)
		begin
			if (wait_count == latency - 1)
			begin
				pmem_resp <= 1'b1;
				if (pmem_write)
				begin
					mem[index] <= pmem_wdata;
					written[index] <= 1'b1;
				end
				else
					pmem_rdata <= written[index] ? mem[index] : fill_pattern(pmem_address);
			end
			else
				wait_count <= wait_count + 1;
		end
		else
			// a dropped request starts over
			wait_count <= 0;
	end

endmodule

/* testbench/prefetcher_tb.sv */
module prefetcher_tb;

	import prefetch_pkg::*;

	localparam int clk_period = 100;
	localparam int pmem_latency = 4;
	// idle to check to response
	localparam int hit_cycles = 2;
	localparam int miss_cycles = hit_cycles + pmem_latency;
	localparam int resp_limit = 64;
	localparam int random_ops = 40;
	localparam int test_ops = 30 + random_ops;
	localparam int op_cycles = 40;
	localparam int watchdog_time = 2 * test_ops * op_cycles * clk_period;

	logic clk = 1'b0;
	logic prefetch_counter_reset;
	addr_t orb;
	logic prefetch_en;
	addr_t l2_address;
	logic l2_read;
	logic l2_write;
	line_t l2_wdata;
	line_t l2_rdata;
	logic l2_resp;
	addr_t pmem_address;
	logic pmem_read;
	logic pmem_write;
	line_t pmem_wdata;
	line_t pmem_rdata;
	logic pmem_resp;

	// pmem traffic as seen at the dut ports
	line_t mirror [addr_t];
	int pmem_reads = 0;
	int pmem_writes = 0;
	logic op_read = 1'b0;
	logic op_write = 1'b0;
	addr_t op_addr = '0;
	line_t op_wdata = '0;
	int checks = 0;
	int errors = 0;

	always #(clk_period / 2) clk = ~clk;

	prefetcher #(.entries(4), .grace_time(20)) dut (.*);

	pmem_model #(.latency(pmem_latency)) memory (.*);

	// op is latched while it waits and counted in its resp cycle
	always @(posedge clk)
	begin
		if (pmem_resp)
		begin
			if (op_read)
				pmem_reads++;
			if (op_write)
			begin
				pmem_writes++;
				mirror[op_addr] = op_wdata;
			end
		end
		else
		begin
			op_read = pmem_read;
			op_write = pmem_write;
			op_addr = pmem_address;
			op_wdata = pmem_wdata;
		end
	end

	function automatic line_t expected_line(input addr_t a);
		line_t l;
		if (mirror.exists(a))
			return mirror[a];
		for (int i = 0; i < 8; i++)
			l[i*32 +: 32] = a ^ (32'(i) * 32'h1111_1111);
		return l;
	endfunction

	function automatic line_t random_line();
		line_t l;
		for (int i = 0; i < 8; i++)
			l[i*32 +: 32] = $urandom();
		return l;
	endfunction

	task automatic check_line(input string what, input line_t got, input line_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp)
		begin
			errors++;
			$display("FAILED at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic l2_access(input logic is_write, input addr_t a, input line_t wdata,
		output line_t rdata, output int cycles);
		bit done;
		@(negedge clk);
		l2_address = a;
		l2_wdata = wdata;
		l2_read = !is_write;
		l2_write = is_write;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < resp_limit)
		begin
			@(negedge clk);
			cycles++;
			done = l2_resp;
		end
		rdata = l2_rdata;
		l2_read = 1'b0;
		l2_write = 1'b0;
		if (!done)
		begin
			errors++;
			$display("no l2_resp for address %h within %0d cycles", a, resp_limit);
		end
	endtask

	task automatic read_and_check(input addr_t a, output int cycles);
		line_t got;
		l2_access(1'b0, a, '0, got, cycles);
		check_line($sformatf("read of %h", a), got, expected_line(a));
	endtask

	task automatic write_line(input addr_t a, input line_t d);
		line_t ignored;
		int cycles;
		l2_access(1'b1, a, d, ignored, cycles);
	endtask

	task automatic start_prefetch(input addr_t a);
		@(negedge clk);
		orb = a;
		prefetch_en = 1'b1;
		@(negedge clk);
		prefetch_en = 1'b0;
	endtask

	// pmem ports idle for three cycles in a row
	task automatic wait_quiet();
		int quiet;
		int n;
		quiet = 0;
		n = 0;
		while (quiet < 3 && n < 200)
		begin
			@(negedge clk);
			n++;
			quiet = (pmem_read || pmem_write) ? 0 : quiet + 1;
		end
		if (quiet < 3)
		begin
			errors++;
			$display("pmem did not go idle within 200 cycles");
		end
	endtask

	task automatic read_miss_goes_to_pmem();
		int reads;
		int cycles;
		reads = pmem_reads;
		read_and_check(32'h1000, cycles);
		wait_quiet();
		check_count("read miss latency", cycles, miss_cycles);
		check_count("read miss pmem reads", pmem_reads - reads, 1);
	endtask

	task automatic prefetched_line_hits();
		int reads;
		int cycles;
		reads = pmem_reads;
		start_prefetch(32'h1040);
		wait_quiet();
		check_count("prefetch pmem reads", pmem_reads - reads, 1);
		reads = pmem_reads;
		read_and_check(32'h1040, cycles);
		wait_quiet();
		check_count("hit latency", cycles, hit_cycles);
		check_count("hit pmem reads", pmem_reads - reads, 0);
	endtask

	task automatic write_clears_entry();
		int writes;
		int cycles;
		writes = pmem_writes;
		write_line(32'h1040, random_line());
		// read before the cleared entry is fetched again
		read_and_check(32'h1040, cycles);
		wait_quiet();
		check_count("read after write latency", cycles, miss_cycles);
		check_count("write through pmem writes", pmem_writes - writes, 1);
	endtask

	task automatic round_robin_refill();
		int reads;
		int cycles;
		addr_t a;
		reads = pmem_reads;
		start_prefetch(32'h1040);
		wait_quiet();
		check_count("held orb pmem reads", pmem_reads - reads, 0);
		// four new lines and the last one reuses the oldest slot
		for (int i = 1; i <= 4; i++)
		begin
			start_prefetch(32'h1040 + 32'(i) * 32'h40);
			wait_quiet();
		end
		check_count("new orb pmem reads", pmem_reads - reads, 4);
		// the evicted line goes to pmem and the four newer ones hit
		reads = pmem_reads;
		for (int i = 0; i <= 4; i++)
		begin
			a = 32'h1040 + 32'(i) * 32'h40;
			read_and_check(a, cycles);
			check_count($sformatf("refill read latency of %h", a), cycles,
				(i == 0) ? miss_cycles : hit_cycles);
		end
		wait_quiet();
		check_count("refill read pmem reads", pmem_reads - reads, 1);
	endtask

	task automatic request_preempts_prefetch();
		int reads;
		int cycles;
		start_prefetch(32'h1180);
		read_and_check(32'h1000, cycles);
		check_count("pre-empting read latency", cycles, miss_cycles);
		wait_quiet();
		reads = pmem_reads;
		read_and_check(32'h1180, cycles);
		wait_quiet();
		check_count("refetched line latency", cycles, hit_cycles);
		check_count("refetched line pmem reads", pmem_reads - reads, 0);
	endtask

	task automatic random_traffic();
		int cycles;
		int writes;
		int expected_writes;
		int kind;
		addr_t a;
		writes = pmem_writes;
		expected_writes = 0;
		for (int n = 0; n < random_ops; n++)
		begin
			a = 32'h2000 + 32'($urandom_range(7, 0)) * 32'h20;
			kind = $urandom_range(2, 0);
			case (kind)
				0: read_and_check(a, cycles);
				1:
				begin
					write_line(a, random_line());
					expected_writes++;
				end
				default: start_prefetch(a);
			endcase
		end
		wait_quiet();
		check_count("random pmem writes", pmem_writes - writes, expected_writes);
	endtask

	initial
	begin
		#(watchdog_time);
		$display("timeout: tests did not finish within %0d time units", watchdog_time);
		$display("sim failed");
		$finish;
	end

	initial
	begin
		void'($urandom(32'h665f));
		orb = '0;
		prefetch_en = 1'b0;
		l2_address = '0;
		l2_read = 1'b0;
		l2_write = 1'b0;
		l2_wdata = '0;
		prefetch_counter_reset = 1'b1;
		repeat (3) @(negedge clk);
		prefetch_counter_reset = 1'b0;
		read_miss_goes_to_pmem();
		prefetched_line_hits();
		write_clears_entry();
		round_robin_refill();
		request_preempts_prefetch();
		random_traffic();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
